// ==== files.f ====
hdl/ecc_field_pkg.sv
hdl/ecc_ctrl_pkg.sv
hdl/field_alu.sv
hdl/scalar_walker.sv
hdl/point_sequencer.sv
hdl/ecc_wb_regs.sv
hdl/ecc_point_mul.sv
tests/tb_clock_gen.sv
tests/tb_ecc_point_mul.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the point multiplier testbench with Verilator and runs it

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_ecc_point_mul --Mdir obj_dir -o sim_tb -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== tests/tb_ecc_point_mul.sv ====
module tb_ecc_point_mul;
    timeunit 1ns;
    timeprecision 100ps;

    import ecc_field_pkg::*;
    import ecc_ctrl_pkg::*;

    localparam int ACK_TIMEOUT   = 16;           // slave has no wait states
    localparam int POLL_TIMEOUT  = 20000;        // status reads per job
    localparam int RESET_TIMEOUT = 20;
    localparam int SMALL_P       = 97;
    localparam int SMALL_A       = 2;
    localparam int SMALL_X       = 3;
    localparam int SMALL_Y       = 6;            // 36 = 27 + 6 + 3
    localparam int BIG_P         = 32749;        // largest prime below 2^15
    localparam int BIG_A         = 12001;
    localparam int BIG_X         = 1234;
    localparam int BIG_Y         = 5678;         // b of this curve follows from the point

    logic    clk;
    logic    rst;
    logic    wb_cyc;
    logic    wb_stb;
    logic    wb_we;
    wb_adr_t wb_adr;
    felem_t  wb_dat_w;
    felem_t  wb_dat_r;
    logic    wb_ack;
    logic    irq;
    int      errors;
    int      timeouts;
    int      seed;

    tb_clock_gen i_tb_clock_gen
    (
        .o_clk   (clk),
        .o_reset (rst)
    );

    ecc_point_mul i_ecc_point_mul
    (
        .i_clk    (clk),
        .i_reset  (rst),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack),
        .o_irq    (irq)
    );

    function automatic int mod_norm(int v, int p);
        int r;
        r = v % p;
        if (r < 0)
            r = r + p;
        return r;
    endfunction

    function automatic int mul_mod(int a, int b, int p);
        longint r;
        r = (longint'(a) * longint'(b)) % longint'(p);
        if (r < 0)
            r = r + longint'(p);
        return int'(r);
    endfunction

    // extended euclid, zero maps to zero
    function automatic int inv_mod(int v, int p);
        int t;
        int new_t;
        int r;
        int new_r;
        int q;
        int tmp;
        t     = 0;
        new_t = 1;
        r     = p;
        new_r = mod_norm(v, p);
        while (new_r != 0)
        begin
            q     = r / new_r;
            tmp   = t - q * new_t;
            t     = new_t;
            new_t = tmp;
            tmp   = r - q * new_r;
            r     = new_r;
            new_r = tmp;
        end
        return mod_norm(t, p);
    endfunction

    // affine double-and-add, top key bit taken as one
    task automatic ref_point_mul(input int key, input int p, input int a, input int x,
                                 input int y, output int rx, output int ry, output bit bad);
        int lam;
        int nx;
        bad = 1'b0;
        rx  = x;
        ry  = y;
        for (int i = KEY_W - 2; i >= 0; i--)
        begin
            if (ry == 0)
                bad = 1'b1;
            lam = mod_norm(mul_mod(3, mul_mod(rx, rx, p), p) + a, p);
            lam = mul_mod(lam, inv_mod(2 * ry, p), p);
            nx  = mod_norm(mul_mod(lam, lam, p) - 2 * rx, p);
            ry  = mod_norm(mul_mod(lam, rx - nx, p) - ry, p);
            rx  = nx;
            if (key[i])
            begin
                if (rx == x)
                    bad = 1'b1;
                lam = mul_mod(y - ry, inv_mod(x - rx, p), p);
                nx  = mod_norm(mul_mod(lam, lam, p) - rx - x, p);
                ry  = mod_norm(mul_mod(lam, rx - nx, p) - ry, p);
                rx  = nx;
            end
        end
    endtask

    task automatic compare_felem(input string name, input felem_t expected, input felem_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH %s: expected 0x%04h actual 0x%04h", name, expected, actual);
        end
    endtask

    task automatic compare_status(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH %s: expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic bus_cycle(input logic we, input wb_adr_t adr, input felem_t dat,
                             output felem_t rdat);
        int n;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        n = 0;
        do
        begin
            @(posedge clk);
            #2;
            n++;
        end
        while (!wb_ack && n < ACK_TIMEOUT);
        if (!wb_ack)
        begin
            timeouts++;
            $display("no acknowledge from the DUT for address %0d", adr);
        end
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_adr_t adr, input felem_t dat);
        felem_t discard;
        bus_cycle(1'b1, adr, dat, discard);
    endtask

    task automatic wb_read(input wb_adr_t adr, output felem_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic wait_done(input string name);
        felem_t st;
        int     n;
        n = 0;
        do
        begin
            wb_read(REG_STATUS, st);
            n++;
        end
        while (!st[STATUS_DONE_BIT] && n < POLL_TIMEOUT);
        if (!st[STATUS_DONE_BIT])
        begin
            timeouts++;
            $display("%s: job did not finish within %0d status reads", name, POLL_TIMEOUT);
        end
    endtask

    task automatic load_params(input int p, input int a, input int x, input int y,
                               input key_t key);
        wb_write(REG_PRIME, felem_t'(p));
        wb_write(REG_CURVE_A, felem_t'(a));
        wb_write(REG_PX, felem_t'(x));
        wb_write(REG_PY, felem_t'(y));
        wb_write(REG_KEY, felem_t'(key));
    endtask

    task automatic check_result(input string name, input int ex, input int ey);
        felem_t rd;
        wb_read(REG_RX, rd);
        compare_felem({name, " rx"}, felem_t'(ex), rd);
        wb_read(REG_RY, rd);
        compare_felem({name, " ry"}, felem_t'(ey), rd);
    endtask

    task automatic run_job(input string name, input int p, input int a, input int x,
                           input int y, input key_t key);
        int ex;
        int ey;
        bit bad;
        ref_point_mul(int'(key), p, a, x, y, ex, ey, bad);
        if (bad)
        begin
            errors++;
            $display("%s: key hits a degenerate step on this curve, nothing to compare", name);
        end
        else
        begin
            load_params(p, a, x, y, key);
            wb_write(REG_CTRL, 16'h0001);
            wait_done(name);
            check_result(name, ex, ey);
        end
    endtask

    task automatic test_register_access();
        felem_t rd;
        load_params(BIG_P, BIG_A, BIG_X, BIG_Y, 16'hA5C3);
        wb_read(REG_PRIME, rd);
        compare_felem("reg prime", felem_t'(BIG_P), rd);
        wb_read(REG_CURVE_A, rd);
        compare_felem("reg curve a", felem_t'(BIG_A), rd);
        wb_read(REG_PX, rd);
        compare_felem("reg px", felem_t'(BIG_X), rd);
        wb_read(REG_PY, rd);
        compare_felem("reg py", felem_t'(BIG_Y), rd);
        wb_read(REG_KEY, rd);
        compare_felem("reg key", 16'hA5C3, rd);
        wb_read(wb_adr_t'(9), rd);
        compare_felem("reg unmapped 9", '0, rd);
        wb_read(wb_adr_t'(15), rd);
        compare_felem("reg unmapped 15", '0, rd);
    endtask

    task automatic test_doubling_only();
        run_job("doubling key 0x8000", SMALL_P, SMALL_A, SMALL_X, SMALL_Y, 16'h8000);
    endtask

    task automatic test_double_and_add();
        run_job("key 0xffff", BIG_P, BIG_A, BIG_X, BIG_Y, 16'hFFFF);
        run_job("key 0x8001", BIG_P, BIG_A, BIG_X, BIG_Y, 16'h8001);
        run_job("key 0x1234", BIG_P, BIG_A, BIG_X, BIG_Y, 16'h1234);   // top bit forced
        run_job("key 0xc35a", BIG_P, BIG_A, BIG_X, BIG_Y, 16'hC35A);
    endtask

    task automatic test_random_keys();
        key_t key;
        int   rnd;
        int   ex;
        int   ey;
        bit   bad;
        int   tries;
        for (int i = 0; i < 8; i++)
        begin
            tries = 0;
            do
            begin
                rnd = $random(seed);
                key = key_t'(rnd);
                ref_point_mul(int'(key), BIG_P, BIG_A, BIG_X, BIG_Y, ex, ey, bad);
                tries++;
            end
            while (bad && tries < 32);
            run_job($sformatf("random key 0x%04h", key), BIG_P, BIG_A, BIG_X, BIG_Y, key);
        end
    endtask

    task automatic test_status_control();
        felem_t st;
        felem_t rd;
        int     ex;
        int     ey;
        bit     bad;
        ref_point_mul(32'hB00B, BIG_P, BIG_A, BIG_X, BIG_Y, ex, ey, bad);
        load_params(BIG_P, BIG_A, BIG_X, BIG_Y, 16'hB00B);
        wb_read(REG_STATUS, st);
        compare_status("done left from last job", 1'b1, st[STATUS_DONE_BIT]);
        wb_write(REG_CTRL, 16'h0001);
        wb_read(REG_STATUS, st);
        compare_status("busy after start", 1'b1, st[STATUS_BUSY_BIT]);
        compare_status("done cleared by start", 1'b0, st[STATUS_DONE_BIT]);
        compare_status("irq cleared by start", 1'b0, irq);
        wb_write(REG_PX, felem_t'(BIG_X + 1));
        wb_write(REG_CTRL, 16'h00FF);             // restart attempt while busy
        wb_read(REG_PX, rd);
        compare_felem("px write while busy", felem_t'(BIG_X), rd);
        wb_read(REG_STATUS, st);
        compare_status("busy after second start", 1'b1, st[STATUS_BUSY_BIT]);
        wait_done("status job");
        wb_read(REG_STATUS, st);
        compare_status("busy after job", 1'b0, st[STATUS_BUSY_BIT]);
        compare_status("done after job", 1'b1, st[STATUS_DONE_BIT]);
        compare_status("irq after job", 1'b1, irq);
        check_result("status job", ex, ey);
        wb_write(REG_CTRL, 16'h0001);
        wb_read(REG_STATUS, st);
        compare_status("done after restart", 1'b0, st[STATUS_DONE_BIT]);
        compare_status("irq after restart", 1'b0, irq);
        wait_done("restart job");
        check_result("restart job", ex, ey);
    endtask

    initial
    begin
        int n;
        errors   = 0;
        timeouts = 0;
        seed     = 32'h716b;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        n = 0;
        while (rst !== 1'b0 && n < RESET_TIMEOUT)
        begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0)
        begin
            timeouts++;
            $display("reset was never released");
        end
        test_register_access();
        test_doubling_only();
        test_double_and_add();
        test_random_keys();
        test_status_control();
        $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
module tb_clock_gen
(
    output logic o_clk,
    output logic o_reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 5;

    initial
    begin
        o_clk = 1'b0;
        forever
            #20 o_clk = ~o_clk;                   // 40 ns period
    end

    initial
    begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES)
            @(posedge o_clk);
        #2 o_reset = 1'b0;
    end

endmodule

// ==== hdl/ecc_point_mul.sv ====
module ecc_point_mul
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  ecc_ctrl_pkg::wb_adr_t i_wb_adr,
    input  ecc_field_pkg::felem_t i_wb_dat,
    output ecc_field_pkg::felem_t o_wb_dat,
    output logic                  o_wb_ack,
    output logic                  o_irq
);
    import ecc_field_pkg::*;
    import ecc_ctrl_pkg::*;

    logic      start;
    logic      busy;
    logic      done;
    felem_t    prime;
    felem_t    curve_a;
    felem_t    px;
    felem_t    py;
    felem_t    rx;
    felem_t    ry;
    key_t      key;
    logic      load;
    logic      shift;
    logic      key_bit;
    logic      key_last;
    logic      alu_start;
    logic      alu_done;
    field_op_t alu_op;
    felem_t    alu_lhs;
    felem_t    alu_rhs;
    felem_t    alu_result;

    ecc_wb_regs i_ecc_wb_regs
    (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_stb  (i_wb_stb),
        .i_wb_we   (i_wb_we),
        .i_wb_adr  (i_wb_adr),
        .i_wb_dat  (i_wb_dat),
        .i_busy    (busy),
        .i_done    (done),
        .i_rx      (rx),
        .i_ry      (ry),
        .o_wb_dat  (o_wb_dat),
        .o_wb_ack  (o_wb_ack),
        .o_irq     (o_irq),
        .o_start   (start),
        .o_prime   (prime),
        .o_curve_a (curve_a),
        .o_px      (px),
        .o_py      (py),
        .o_key     (key)
    );

    point_sequencer i_point_sequencer
    (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_start      (start),
        .i_curve_a    (curve_a),
        .i_px         (px),
        .i_py         (py),
        .i_bit        (key_bit),
        .i_last       (key_last),
        .i_alu_done   (alu_done),
        .i_alu_result (alu_result),
        .o_busy       (busy),
        .o_done       (done),
        .o_rx         (rx),
        .o_ry         (ry),
        .o_load       (load),
        .o_shift      (shift),
        .o_alu_start  (alu_start),
        .o_alu_op     (alu_op),
        .o_alu_lhs    (alu_lhs),
        .o_alu_rhs    (alu_rhs)
    );

    scalar_walker i_scalar_walker
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_load  (load),
        .i_shift (shift),
        .i_key   (key),
        .o_bit   (key_bit),
        .o_last  (key_last)
    );

    field_alu i_field_alu
    (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_start  (alu_start),
        .i_op     (alu_op),
        .i_prime  (prime),
        .i_lhs    (alu_lhs),
        .i_rhs    (alu_rhs),
        .o_done   (alu_done),
        .o_result (alu_result)
    );

endmodule

// ==== hdl/ecc_wb_regs.sv ====
module ecc_wb_regs
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  ecc_ctrl_pkg::wb_adr_t i_wb_adr,
    input  ecc_field_pkg::felem_t i_wb_dat,
    input  logic                  i_busy,
    input  logic                  i_done,
    input  ecc_field_pkg::felem_t i_rx,
    input  ecc_field_pkg::felem_t i_ry,
    output ecc_field_pkg::felem_t o_wb_dat,
    output logic                  o_wb_ack,
    output logic                  o_irq,
    output logic                  o_start,
    output ecc_field_pkg::felem_t o_prime,
    output ecc_field_pkg::felem_t o_curve_a,
    output ecc_field_pkg::felem_t o_px,
    output ecc_field_pkg::felem_t o_py,
    output ecc_ctrl_pkg::key_t    o_key
);
    import ecc_field_pkg::*;
    import ecc_ctrl_pkg::*;

    logic   wb_req;
    logic   wb_wr;
    felem_t rx_r;
    felem_t ry_r;
    felem_t rd_data;

    assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;   // master still holds stb during ack
    assign wb_wr  = wb_req && i_wb_we && !i_busy;        // acked but dropped while busy

    always_comb
    begin
        rd_data = '0;
        case (i_wb_adr)
            REG_STATUS:
            begin
                rd_data[STATUS_BUSY_BIT] = i_busy;
                rd_data[STATUS_DONE_BIT] = o_irq;
            end
            REG_PRIME:   rd_data = o_prime;
            REG_CURVE_A: rd_data = o_curve_a;
            REG_PX:      rd_data = o_px;
            REG_PY:      rd_data = o_py;
            REG_KEY:     rd_data = felem_t'(o_key);
            REG_RX:      rd_data = rx_r;
            REG_RY:      rd_data = ry_r;
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            o_wb_ack <= 1'b0;
            o_start  <= 1'b0;
            o_irq    <= 1'b0;
        end
        else
        begin
            o_wb_ack <= wb_req;
            o_start  <= wb_wr && (i_wb_adr == REG_CTRL) && i_wb_dat[0];
            if (i_done)
                o_irq <= 1'b1;                    // sticky done
            else if (o_start)
                o_irq <= 1'b0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (wb_wr)
        begin
            case (i_wb_adr)
                REG_PRIME:   o_prime   <= i_wb_dat;
                REG_CURVE_A: o_curve_a <= i_wb_dat;
                REG_PX:      o_px      <= i_wb_dat;
                REG_PY:      o_py      <= i_wb_dat;
                REG_KEY:     o_key     <= key_t'(i_wb_dat);
                default:     ;
            endcase
        end
        if (i_done)
        begin
            rx_r <= i_rx;
            ry_r <= i_ry;
        end
        if (wb_req)
            o_wb_dat <= rd_data;
    end

endmodule

// ==== hdl/point_sequencer.sv ====
module point_sequencer
(
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_start,
    input  ecc_field_pkg::felem_t    i_curve_a,
    input  ecc_field_pkg::felem_t    i_px,
    input  ecc_field_pkg::felem_t    i_py,
    input  logic                     i_bit,
    input  logic                     i_last,
    input  logic                     i_alu_done,
    input  ecc_field_pkg::felem_t    i_alu_result,
    output logic                     o_busy,
    output logic                     o_done,
    output ecc_field_pkg::felem_t    o_rx,
    output ecc_field_pkg::felem_t    o_ry,
    output logic                     o_load,
    output logic                     o_shift,
    output logic                     o_alu_start,
    output ecc_field_pkg::field_op_t o_alu_op,
    output ecc_field_pkg::felem_t    o_alu_lhs,
    output ecc_field_pkg::felem_t    o_alu_rhs
);
    import ecc_field_pkg::*;
    import ecc_ctrl_pkg::*;

    seq_state_t state;
    logic       alu_wait;                         // op issued, result pending
    logic       finish;
    felem_t     rx;
    felem_t     ry;
    felem_t     px;
    felem_t     py;
    felem_t     a_r;
    felem_t     r1;
    felem_t     r2;
    felem_t     x3;

    // DBL_0 entry is where the next bit, or the end, is decided
    assign finish      = (state == DBL_0) && !alu_wait && i_last;
    assign o_busy      = (state != SEQ_IDLE);
    assign o_done      = finish;
    assign o_load      = (state == SEQ_IDLE) && i_start;
    assign o_shift     = i_alu_done && ((state == DBL_11 && !i_bit) || state == ADD_8);
    assign o_alu_start = o_busy && !alu_wait && !finish;
    assign o_rx        = rx;
    assign o_ry        = ry;

    always_comb
    begin
        case (state)
            DBL_0, DBL_6, DBL_10, ADD_3, ADD_7: o_alu_op = FOP_MUL;
            DBL_1, DBL_2, DBL_3, DBL_4:         o_alu_op = FOP_ADD;
            DBL_5, ADD_2:                       o_alu_op = FOP_DIV;
            default:                            o_alu_op = FOP_SUB;
        endcase
    end

    always_comb
    begin
        case (state)
            DBL_0:                       {o_alu_lhs, o_alu_rhs} = {rx, rx};
            DBL_1, DBL_6, ADD_3:         {o_alu_lhs, o_alu_rhs} = {r1, r1};
            DBL_2, DBL_5, DBL_10, ADD_7: {o_alu_lhs, o_alu_rhs} = {r1, r2};
            DBL_3:                       {o_alu_lhs, o_alu_rhs} = {r1, a_r};
            DBL_4:                       {o_alu_lhs, o_alu_rhs} = {ry, ry};
            DBL_7, DBL_8, ADD_4:         {o_alu_lhs, o_alu_rhs} = {r2, rx};
            DBL_9, ADD_6:                {o_alu_lhs, o_alu_rhs} = {rx, x3};
            DBL_11, ADD_8:               {o_alu_lhs, o_alu_rhs} = {r2, ry};
            ADD_0:                       {o_alu_lhs, o_alu_rhs} = {px, rx};
            ADD_1:                       {o_alu_lhs, o_alu_rhs} = {py, ry};
            ADD_2:                       {o_alu_lhs, o_alu_rhs} = {r2, r1};
            ADD_5:                       {o_alu_lhs, o_alu_rhs} = {r2, px};
            default:                     {o_alu_lhs, o_alu_rhs} = '0;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state    <= SEQ_IDLE;
            alu_wait <= 1'b0;
        end
        else
        begin
            if (o_alu_start)
                alu_wait <= 1'b1;
            else if (i_alu_done)
                alu_wait <= 1'b0;

            if (state == SEQ_IDLE)
            begin
                if (i_start)
                    state <= DBL_0;
            end
            else if (finish)
                state <= SEQ_IDLE;
            else if (i_alu_done)
            begin
                case (state)
                    DBL_11:  state <= i_bit ? ADD_0 : DBL_0;
                    ADD_8:   state <= DBL_0;
                    default: state <= seq_state_t'(state + 1'b1);
                endcase
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (o_load)
        begin
            rx  <= i_px;                          // R starts as P
            ry  <= i_py;
            px  <= i_px;
            py  <= i_py;
            a_r <= i_curve_a;
        end
        if (i_alu_done)
        begin
            case (state)
                DBL_0, DBL_2, DBL_3, DBL_5, ADD_0, ADD_2:
                    r1 <= i_alu_result;
                DBL_8, ADD_5:
                    x3 <= i_alu_result;
                DBL_11, ADD_8:
                begin
                    rx <= x3;
                    ry <= i_alu_result;
                end
                default:
                    r2 <= i_alu_result;
            endcase
        end
    end

    a_state_legal: assert property (@(posedge i_clk) disable iff (i_reset)
        state inside {[SEQ_IDLE:ADD_8]});

    // no stray ALU result outside a job
    a_idle_quiet: assert property (@(posedge i_clk) disable iff (i_reset)
        state == SEQ_IDLE |-> !i_alu_done);

endmodule

// ==== hdl/scalar_walker.sv ====
module scalar_walker
(
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_load,
    input  logic               i_shift,
    input  ecc_ctrl_pkg::key_t i_key,
    output logic               o_bit,
    output logic               o_last
);
    import ecc_ctrl_pkg::*;

    key_t              key_sr;                    // current bit at the msb
    logic [STEP_W-1:0] count;                     // bits left to consume

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
            count <= '0;
        else if (i_load)
            count <= STEP_W'(KEY_W - 1);
        else if (i_shift)
            count <= count - 1'b1;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_load)
            key_sr <= {i_key[KEY_W-2:0], 1'b0};   // top bit is always one
        else if (i_shift)
            key_sr <= key_sr << 1;
    end

    assign o_bit  = key_sr[KEY_W-1];
    assign o_last = (count == '0);

    // sequencer must check o_last before consuming another bit
    a_no_shift_empty: assert property (@(posedge i_clk) disable iff (i_reset)
        i_shift |-> count != '0);

endmodule

// ==== hdl/field_alu.sv ====
module field_alu
(
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_start,
    input  ecc_field_pkg::field_op_t i_op,
    input  ecc_field_pkg::felem_t    i_prime,
    input  ecc_field_pkg::felem_t    i_lhs,
    input  ecc_field_pkg::felem_t    i_rhs,
    output logic                     o_done,
    output ecc_field_pkg::felem_t    o_result
);
    import ecc_field_pkg::*;

    typedef enum logic [2:0]
    {
        PH_IDLE,
        PH_MUL,
        PH_SQR,                                   // divide: square the running power
        PH_EMUL,                                  // divide: multiply in the base
        PH_FIN                                    // divide: times lhs
    } phase_t;

    phase_t   phase;
    felem_t   prime_r;
    felem_t   exp_r;                              // p-2
    felem_t   base_r;
    felem_t   lhs_r;
    felem_t   mul_x;                              // scanned msb first
    felem_t   mul_y;
    felem_t   acc;
    felem_t   acc_next;
    bit_idx_t mcnt;
    bit_idx_t ecnt;

    function automatic felem_t add_mod(felem_t a, felem_t b, felem_t p);
        logic [FELEM_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, p})
            s = s - {1'b0, p};
        return s[FELEM_W-1:0];
    endfunction

    function automatic felem_t sub_mod(felem_t a, felem_t b, felem_t p);
        felem_t d;
        d = a - b;
        if (a < b)
            d = d + p;                            // wraps back into range
        return d;
    endfunction

    // one step of the interleaved multiply: acc = 2*acc + bit*y
    always_comb
    begin
        acc_next = add_mod(acc, acc, prime_r);
        if (mul_x[mcnt])
            acc_next = add_mod(acc_next, mul_y, prime_r);
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            phase    <= PH_IDLE;
            o_done   <= 1'b0;
            o_result <= '0;
            prime_r  <= '0;
            exp_r    <= '0;
            base_r   <= '0;
            lhs_r    <= '0;
            mul_x    <= '0;
            mul_y    <= '0;
            acc      <= '0;
            mcnt     <= '0;
            ecnt     <= '0;
        end
        else
        begin
            o_done <= 1'b0;
            if (phase == PH_IDLE)
            begin
                if (i_start)
                begin
                    prime_r <= i_prime;
                    exp_r   <= i_prime - felem_t'(2);
                    base_r  <= i_rhs;
                    lhs_r   <= i_lhs;
                    acc     <= '0;
                    mcnt    <= bit_idx_t'(FELEM_W - 1);
                    ecnt    <= bit_idx_t'(FELEM_W - 1);
                    mul_x   <= i_lhs;
                    mul_y   <= i_rhs;
                    case (i_op)
                        FOP_ADD:
                        begin
                            o_result <= add_mod(i_lhs, i_rhs, i_prime);
                            o_done   <= 1'b1;
                        end
                        FOP_SUB:
                        begin
                            o_result <= sub_mod(i_lhs, i_rhs, i_prime);
                            o_done   <= 1'b1;
                        end
                        FOP_MUL:
                            phase <= PH_MUL;
                        default:
                        begin
                            mul_x <= felem_t'(1);     // power starts at one
                            mul_y <= felem_t'(1);
                            phase <= PH_SQR;
                        end
                    endcase
                end
            end
            else
            begin
                acc  <= acc_next;
                mcnt <= mcnt - 1'b1;
                if (mcnt == '0)
                begin
                    acc   <= '0;
                    mcnt  <= bit_idx_t'(FELEM_W - 1);
                    mul_x <= acc_next;
                    if (phase == PH_MUL || phase == PH_FIN)
                    begin
                        o_result <= acc_next;
                        o_done   <= 1'b1;
                        phase    <= PH_IDLE;
                    end
                    else if (phase == PH_SQR && exp_r[ecnt])
                    begin
                        mul_y <= base_r;
                        phase <= PH_EMUL;
                    end
                    else if (ecnt == '0)
                    begin
                        mul_y <= lhs_r;           // inverse done
                        phase <= PH_FIN;
                    end
                    else
                    begin
                        mul_y <= acc_next;
                        ecnt  <= ecnt - 1'b1;
                        phase <= PH_SQR;
                    end
                end
            end
        end
    end

    // the sequencer waits for done before issuing the next op
    a_no_start_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        i_start |-> phase == PH_IDLE);

endmodule

// ==== hdl/ecc_ctrl_pkg.sv ====
package ecc_ctrl_pkg;

    localparam int KEY_W    = 16;
    localparam int STEP_W   = 4;                  // holds KEY_W-1
    localparam int WB_ADR_W = 4;

    typedef logic [KEY_W-1:0]    key_t;
    typedef logic [WB_ADR_W-1:0] wb_adr_t;

    typedef enum logic [4:0]
    {
        SEQ_IDLE,
        DBL_0, DBL_1, DBL_2, DBL_3, DBL_4, DBL_5,
        DBL_6, DBL_7, DBL_8, DBL_9, DBL_10, DBL_11,
        ADD_0, ADD_1, ADD_2, ADD_3, ADD_4,
        ADD_5, ADD_6, ADD_7, ADD_8
    } seq_state_t;

    localparam wb_adr_t REG_CTRL    = 4'd0;
    localparam wb_adr_t REG_STATUS  = 4'd1;
    localparam wb_adr_t REG_PRIME   = 4'd2;
    localparam wb_adr_t REG_CURVE_A = 4'd3;
    localparam wb_adr_t REG_PX      = 4'd4;
    localparam wb_adr_t REG_PY      = 4'd5;
    localparam wb_adr_t REG_KEY     = 4'd6;
    localparam wb_adr_t REG_RX      = 4'd7;
    localparam wb_adr_t REG_RY      = 4'd8;

    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

endpackage

// ==== hdl/ecc_field_pkg.sv ====
package ecc_field_pkg;

    localparam int FELEM_W   = 16;
    localparam int BIT_IDX_W = 4;                 // selects one bit of a field element

    typedef logic [FELEM_W-1:0]   felem_t;
    typedef logic [BIT_IDX_W-1:0] bit_idx_t;

    typedef enum logic [1:0]
    {
        FOP_ADD = 2'b00,
        FOP_SUB = 2'b01,
        FOP_MUL = 2'b10,
        FOP_DIV = 2'b11
    } field_op_t;

endpackage
